// ==== Makefile ====
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --top-module tb_segre_core -f filelist.f

run: compile
	-./obj_dir/Vtb_segre_core > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Regression failed" $(LOG); then exit 1; fi
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== filelist.f ====
segre_pkg.sv
segre_if_stage.sv
segre_id_stage.sv
segre_ex_stage.sv
segre_register_file.sv
segre_mmu.sv
segre_core.sv
tb_segre_core.sv

// ==== segre_core.sv ====
`timescale 1ns/1ps

module segre_core import segre_pkg::*; (
    // Clock and reset
    input  logic                 clk_i,
    input  logic                 rst_n_i,

    // Main memory
    input  logic                 mm_data_rdy_i,
    input  logic [WORD_SIZE-1:0] mm_rd_data_i,
    output logic [WORD_SIZE-1:0] mm_wr_data_o,
    output logic [ADDR_SIZE-1:0] mm_addr_o,
    output logic [ADDR_SIZE-1:0] mm_wr_addr_o,
    output logic                 mm_rd_o,
    output logic                 mm_wr_o
);

if_id_t                   if_id;
id_ex_t                   id_ex;
rf_wdata_t                rf_wdata;
mem_req_t                 fetch_req;
mem_req_t                 data_req;
logic                     fetch_ack;
logic                     data_ack;
logic [WORD_SIZE-1:0]     mmu_rdata;
logic [REG_ADDR_SIZE-1:0] raddr_a;
logic [REG_ADDR_SIZE-1:0] raddr_b;
logic [WORD_SIZE-1:0]     data_a;
logic [WORD_SIZE-1:0]     data_b;
logic                     tkbr;
logic [ADDR_SIZE-1:0]     new_pc;
logic                     ex_busy;
logic                     id_stall;
logic                     if_hazard;
logic                     id_hazard;

// Fetch waits on either later stage, decode only on a pending memory access
assign if_hazard = ex_busy | id_stall;
assign id_hazard = ex_busy;

segre_if_stage if_stage (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .hazard_i     (if_hazard),
    .tkbr_i       (tkbr),
    .new_pc_i     (new_pc),
    .fetch_req_o  (fetch_req),
    .fetch_ack_i  (fetch_ack),
    .fetch_data_i (mmu_rdata),
    .if_id_o      (if_id)
);

segre_id_stage id_stage (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .hazard_i   (id_hazard),
    .flush_i    (tkbr),
    .if_id_i    (if_id),
    .raddr_a_o  (raddr_a),
    .raddr_b_o  (raddr_b),
    .data_a_i   (data_a),
    .data_b_i   (data_b),
    .ex_dest_i  (id_ex),
    .wb_i       (rf_wdata),
    .id_stall_o (id_stall),
    .id_ex_o    (id_ex)
);

segre_ex_stage ex_stage (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .id_ex_i      (id_ex),
    .data_req_o   (data_req),
    .data_ack_i   (data_ack),
    .data_rdata_i (mmu_rdata),
    .rf_wdata_o   (rf_wdata),
    .tkbr_o       (tkbr),
    .new_pc_o     (new_pc),
    .ex_busy_o    (ex_busy)
);

segre_register_file segre_rf (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .raddr_a_i (raddr_a),
    .raddr_b_i (raddr_b),
    .data_a_o  (data_a),
    .data_b_o  (data_b),
    .wdata_i   (rf_wdata)
);

segre_mmu mmu (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .fetch_req_i   (fetch_req),
    .data_req_i    (data_req),
    .fetch_ack_o   (fetch_ack),
    .data_ack_o    (data_ack),
    .rdata_o       (mmu_rdata),
    .mm_data_rdy_i (mm_data_rdy_i),
    .mm_rd_data_i  (mm_rd_data_i),
    .mm_rd_o       (mm_rd_o),
    .mm_wr_o       (mm_wr_o),
    .mm_addr_o     (mm_addr_o),
    .mm_wr_addr_o  (mm_wr_addr_o),
    .mm_wr_data_o  (mm_wr_data_o)
);

endmodule : segre_core

// ==== segre_ex_stage.sv ====
`timescale 1ns/1ps

module segre_ex_stage import segre_pkg::*; (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  id_ex_t               id_ex_i,
    output mem_req_t             data_req_o,
    input  logic                 data_ack_i,
    input  logic [WORD_SIZE-1:0] data_rdata_i,
    output rf_wdata_t            rf_wdata_o,
    output logic                 tkbr_o,
    output logic [ADDR_SIZE-1:0] new_pc_o,
    output logic                 ex_busy_o
);

logic [WORD_SIZE-1:0] alu_res;
logic                 alu_zero;
logic                 mem_op;
logic                 issued_q;
logic                 wr_q;
logic [ADDR_SIZE-1:0] addr_q;
logic [WORD_SIZE-1:0] wdata_q;

always_comb begin
    case (id_ex_i.alu_op)
        ALU_ADD:    alu_res = id_ex_i.operand_a + id_ex_i.operand_b;
        ALU_SUB:    alu_res = id_ex_i.operand_a - id_ex_i.operand_b;
        ALU_AND:    alu_res = id_ex_i.operand_a & id_ex_i.operand_b;
        ALU_OR:     alu_res = id_ex_i.operand_a | id_ex_i.operand_b;
        ALU_XOR:    alu_res = id_ex_i.operand_a ^ id_ex_i.operand_b;
        ALU_PASS_B: alu_res = id_ex_i.operand_b;
        default:    alu_res = id_ex_i.operand_a + id_ex_i.operand_b;
    endcase
end

assign alu_zero = (alu_res == '0);

// BEQ is taken on equal operands, BNE on different ones
assign tkbr_o   = id_ex_i.valid && id_ex_i.is_branch && (id_ex_i.branch_eq == alu_zero);
assign new_pc_o = id_ex_i.br_target;

assign mem_op    = id_ex_i.valid && (id_ex_i.memop_rd || id_ex_i.memop_wr);
assign ex_busy_o = mem_op && !data_ack_i;

always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        issued_q <= 1'b0;
    end else if (data_ack_i) begin
        issued_q <= 1'b0;
    end else if (mem_op) begin
        issued_q <= 1'b1;
    end
end

// Request fields captured on the first EX cycle and held until the ack
always_ff @(posedge clk_i) begin
    if (mem_op && !issued_q) begin
        wr_q    <= id_ex_i.memop_wr;
        addr_q  <= alu_res;
        wdata_q <= id_ex_i.store_data;
    end
end

// Dropped in the ack cycle so the MMU does not take the same access twice
assign data_req_o.req   = issued_q && !data_ack_i;
assign data_req_o.wr    = wr_q;
assign data_req_o.addr  = addr_q;
assign data_req_o.wdata = wdata_q;

// Loads write back on the ack, ALU results at the end of this cycle
assign rf_wdata_o.we    = id_ex_i.valid && id_ex_i.rf_we && (id_ex_i.rf_waddr != '0)
                          && (!id_ex_i.memop_rd || data_ack_i);
assign rf_wdata_o.waddr = id_ex_i.rf_waddr;
assign rf_wdata_o.data  = id_ex_i.memop_rd ? data_rdata_i : alu_res;

endmodule : segre_ex_stage

// ==== segre_id_stage.sv ====
`timescale 1ns/1ps

module segre_id_stage import segre_pkg::*; (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     hazard_i,
    input  logic                     flush_i,
    input  if_id_t                   if_id_i,
    output logic [REG_ADDR_SIZE-1:0] raddr_a_o,
    output logic [REG_ADDR_SIZE-1:0] raddr_b_o,
    input  logic [WORD_SIZE-1:0]     data_a_i,
    input  logic [WORD_SIZE-1:0]     data_b_i,
    input  id_ex_t                   ex_dest_i,
    input  rf_wdata_t                wb_i,
    output logic                     id_stall_o,
    output id_ex_t                   id_ex_o
);

instr_u               instr;
logic [WORD_SIZE-1:0] imm_i;
logic [WORD_SIZE-1:0] imm_s;
logic [WORD_SIZE-1:0] imm_b;
logic [WORD_SIZE-1:0] imm_u;
logic [WORD_SIZE-1:0] rs1_val;
logic [WORD_SIZE-1:0] rs2_val;
logic                 use_a;
logic                 use_b;
logic                 ex_pending;
logic                 raw_a;
logic                 raw_b;
id_ex_t               dec;
id_ex_t               id_ex_q;

function automatic alu_op_e funct3_to_alu(input logic [2:0] funct3, input logic sub);
    case (funct3)
        3'b100:  return ALU_XOR;
        3'b110:  return ALU_OR;
        3'b111:  return ALU_AND;
        default: return sub ? ALU_SUB : ALU_ADD;
    endcase
endfunction

assign instr     = if_id_i.instr;
assign raddr_a_o = instr.r.rs1;
assign raddr_b_o = instr.r.rs2;

assign imm_i = {{20{instr.i.imm[11]}}, instr.i.imm};
assign imm_s = {{20{instr.s.imm_11_5[6]}}, instr.s.imm_11_5, instr.s.imm_4_0};
assign imm_b = {{20{instr.b.imm_12}}, instr.b.imm_11, instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
assign imm_u = {instr.u.imm_31_12, 12'b0};

// The register file writes at the edge, so take this cycle's write directly
assign rs1_val = (wb_i.we && wb_i.waddr == raddr_a_o) ? wb_i.data : data_a_i;
assign rs2_val = (wb_i.we && wb_i.waddr == raddr_b_o) ? wb_i.data : data_b_i;

always_comb begin
    dec            = '0;
    dec.valid      = if_id_i.valid;
    dec.alu_op     = ALU_ADD;
    dec.operand_a  = rs1_val;
    dec.operand_b  = rs2_val;
    dec.store_data = rs2_val;
    dec.br_target  = if_id_i.pc + imm_b;
    dec.rf_waddr   = instr.r.rd;
    use_a          = 1'b0;
    use_b          = 1'b0;
    case (instr.r.opcode)
        OPCODE_OP: begin
            use_a      = 1'b1;
            use_b      = 1'b1;
            dec.alu_op = funct3_to_alu(instr.r.funct3, instr.r.funct7[5]);
            dec.rf_we  = instr.r.funct3 inside {3'b000, 3'b100, 3'b110, 3'b111};
        end
        OPCODE_OP_IMM: begin
            use_a         = 1'b1;
            dec.operand_b = imm_i;
            dec.alu_op    = funct3_to_alu(instr.i.funct3, 1'b0);
            dec.rf_we     = instr.i.funct3 inside {3'b000, 3'b100, 3'b110, 3'b111};
        end
        OPCODE_LUI: begin
            dec.alu_op    = ALU_PASS_B;
            dec.operand_b = imm_u;
            dec.rf_we     = 1'b1;
        end
        OPCODE_LOAD: begin
            use_a         = 1'b1;
            dec.operand_b = imm_i;
            dec.memop_rd  = 1'b1;
            dec.rf_we     = 1'b1;
        end
        OPCODE_STORE: begin
            use_a         = 1'b1;
            use_b         = 1'b1;
            dec.operand_b = imm_s;
            dec.memop_wr  = 1'b1;
        end
        OPCODE_BRANCH: begin
            // Compare through SUB; only BEQ and BNE count as branches
            use_a         = 1'b1;
            use_b         = 1'b1;
            dec.alu_op    = ALU_SUB;
            dec.branch_eq = (instr.b.funct3 == 3'b000);
            dec.is_branch = (instr.b.funct3 == 3'b000) || (instr.b.funct3 == 3'b001);
        end
        // Anything else passes through as a no-op
        default: ;
    endcase
end

// EX still owes a write to a register we need
assign ex_pending = ex_dest_i.valid && ex_dest_i.rf_we && (ex_dest_i.rf_waddr != '0)
                    && !wb_i.we;
assign raw_a      = use_a && ex_pending && (ex_dest_i.rf_waddr == raddr_a_o);
assign raw_b      = use_b && ex_pending && (ex_dest_i.rf_waddr == raddr_b_o);
assign id_stall_o = if_id_i.valid && (raw_a || raw_b);

always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        id_ex_q <= '0;
    end else if (flush_i) begin
        id_ex_q.valid <= 1'b0;
    end else if (!hazard_i) begin
        if (id_stall_o) begin
            id_ex_q.valid <= 1'b0;
        end else begin
            id_ex_q <= dec;
        end
    end
end

assign id_ex_o = id_ex_q;

endmodule : segre_id_stage

// ==== segre_if_stage.sv ====
`timescale 1ns/1ps

module segre_if_stage import segre_pkg::*; (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 hazard_i,
    input  logic                 tkbr_i,
    input  logic [ADDR_SIZE-1:0] new_pc_i,
    output mem_req_t             fetch_req_o,
    input  logic                 fetch_ack_i,
    input  logic [WORD_SIZE-1:0] fetch_data_i,
    output if_id_t               if_id_o
);

logic [ADDR_SIZE-1:0] pc_q;
logic                 redir_q;
logic [ADDR_SIZE-1:0] redir_pc_q;
if_id_t               if_id_q;

// Fetch only into an empty IF/ID register, so an ack always has a place to land
assign fetch_req_o.req   = ~if_id_q.valid & ~fetch_ack_i;
assign fetch_req_o.wr    = 1'b0;
assign fetch_req_o.addr  = pc_q;
assign fetch_req_o.wdata = '0;

always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        pc_q       <= RESET_PC;
        redir_q    <= 1'b0;
        redir_pc_q <= RESET_PC;
        if_id_q    <= '0;
    end else if (tkbr_i) begin
        if_id_q.valid <= 1'b0;
        // A fetch may already sit in the MMU, so wait for its ack and drop it
        if (fetch_req_o.req) begin
            redir_q    <= 1'b1;
            redir_pc_q <= new_pc_i;
        end else begin
            pc_q <= new_pc_i;
        end
    end else if (fetch_ack_i) begin
        if (redir_q) begin
            redir_q <= 1'b0;
            pc_q    <= redir_pc_q;
        end else begin
            if_id_q.valid <= 1'b1;
            if_id_q.pc    <= pc_q;
            if_id_q.instr <= fetch_data_i;
            pc_q          <= pc_q + ADDR_SIZE'(4);
        end
    end else if (if_id_q.valid && !hazard_i) begin
        // Decode takes the instruction this cycle
        if_id_q.valid <= 1'b0;
    end
end

assign if_id_o = if_id_q;

endmodule : segre_if_stage

// ==== segre_mmu.sv ====
`timescale 1ns/1ps

module segre_mmu import segre_pkg::*; (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  mem_req_t             fetch_req_i,
    input  mem_req_t             data_req_i,
    output logic                 fetch_ack_o,
    output logic                 data_ack_o,
    output logic [WORD_SIZE-1:0] rdata_o,
    input  logic                 mm_data_rdy_i,
    input  logic [WORD_SIZE-1:0] mm_rd_data_i,
    output logic                 mm_rd_o,
    output logic                 mm_wr_o,
    output logic [ADDR_SIZE-1:0] mm_addr_o,
    output logic [ADDR_SIZE-1:0] mm_wr_addr_o,
    output logic [WORD_SIZE-1:0] mm_wr_data_o
);

typedef enum logic {
    MMU_IDLE,
    MMU_BUSY
} mmu_state_e;

mmu_state_e state_q;
mem_req_t   lat_q;
logic       owner_data_q;

always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        state_q      <= MMU_IDLE;
        owner_data_q <= 1'b0;
        fetch_ack_o  <= 1'b0;
        data_ack_o   <= 1'b0;
    end else begin
        fetch_ack_o <= 1'b0;
        data_ack_o  <= 1'b0;
        case (state_q)
            MMU_IDLE: begin
                // Data side wins when both ask in the same cycle
                if (data_req_i.req || fetch_req_i.req) begin
                    state_q      <= MMU_BUSY;
                    owner_data_q <= data_req_i.req;
                end
            end
            MMU_BUSY: begin
                if (mm_data_rdy_i) begin
                    state_q     <= MMU_IDLE;
                    data_ack_o  <= owner_data_q;
                    fetch_ack_o <= !owner_data_q;
                end
            end
            default: state_q <= MMU_IDLE;
        endcase
    end
end

always_ff @(posedge clk_i) begin
    if (state_q == MMU_IDLE) begin
        lat_q <= data_req_i.req ? data_req_i : fetch_req_i;
    end
    if (state_q == MMU_BUSY && mm_data_rdy_i) begin
        rdata_o <= mm_rd_data_i;
    end
end

// Main memory sees only the latched request, steady until ready
assign mm_rd_o      = (state_q == MMU_BUSY) && lat_q.req && !lat_q.wr;
assign mm_wr_o      = (state_q == MMU_BUSY) && lat_q.req && lat_q.wr;
assign mm_addr_o    = lat_q.addr;
assign mm_wr_addr_o = lat_q.addr;
assign mm_wr_data_o = lat_q.wdata;

endmodule : segre_mmu

// ==== segre_pkg.sv ====
package segre_pkg;

// Datapath sizes
localparam int ADDR_SIZE     = 32;
localparam int WORD_SIZE     = 32;
localparam int REG_ADDR_SIZE = 5;

localparam logic [ADDR_SIZE-1:0] RESET_PC = '0;

// RV32I base opcodes handled by the core
localparam logic [6:0] OPCODE_OP     = 7'b0110011;
localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
localparam logic [6:0] OPCODE_LUI    = 7'b0110111;
localparam logic [6:0] OPCODE_LOAD   = 7'b0000011;
localparam logic [6:0] OPCODE_STORE  = 7'b0100011;
localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;

typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_PASS_B
} alu_op_e;

// Instruction formats with fields listed from bit 31 down
typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
} r_fmt_t;

typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
} i_fmt_t;

typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
} s_fmt_t;

typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
} b_fmt_t;

typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
} u_fmt_t;

typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
} instr_u;

typedef struct packed {
    logic                 valid;
    logic [ADDR_SIZE-1:0] pc;
    instr_u               instr;
} if_id_t;

typedef struct packed {
    logic                     valid;
    alu_op_e                  alu_op;
    logic [WORD_SIZE-1:0]     operand_a;
    logic [WORD_SIZE-1:0]     operand_b;
    logic [WORD_SIZE-1:0]     store_data;
    logic [ADDR_SIZE-1:0]     br_target;
    logic                     branch_eq;
    logic                     is_branch;
    logic                     memop_rd;
    logic                     memop_wr;
    logic                     rf_we;
    logic [REG_ADDR_SIZE-1:0] rf_waddr;
} id_ex_t;

typedef struct packed {
    logic                     we;
    logic [REG_ADDR_SIZE-1:0] waddr;
    logic [WORD_SIZE-1:0]     data;
} rf_wdata_t;

typedef struct packed {
    logic                 req;
    logic                 wr;
    logic [ADDR_SIZE-1:0] addr;
    logic [WORD_SIZE-1:0] wdata;
} mem_req_t;

endpackage : segre_pkg

// ==== segre_register_file.sv ====
`timescale 1ns/1ps

module segre_register_file import segre_pkg::*; (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic [REG_ADDR_SIZE-1:0] raddr_a_i,
    input  logic [REG_ADDR_SIZE-1:0] raddr_b_i,
    output logic [WORD_SIZE-1:0]     data_a_o,
    output logic [WORD_SIZE-1:0]     data_b_o,
    input  rf_wdata_t                wdata_i
);

logic [WORD_SIZE-1:0] regs_q [2**REG_ADDR_SIZE];

always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        for (int i = 0; i < 2**REG_ADDR_SIZE; i++) begin
            regs_q[i] <= '0;
        end
    end else if (wdata_i.we && wdata_i.waddr != '0) begin
        // x0 is never written and keeps its reset value of zero
        regs_q[wdata_i.waddr] <= wdata_i.data;
    end
end

assign data_a_o = regs_q[raddr_a_i];
assign data_b_o = regs_q[raddr_b_i];

endmodule : segre_register_file

// ==== tb_segre_core.sv ====
`timescale 1ns/1ps

module tb_segre_core;

localparam int CLK_HALF       = 20;
localparam int RESET_CYCLES   = 5;
localparam int MAX_LATENCY    = 4;
localparam int PIPE_CYCLES    = 3;
localparam int REFETCH_FACTOR = 3;
localparam int DRAIN_CYCLES   = 20;
localparam int MEM_WORDS      = 256;
localparam int MEM_BYTES      = 1024;

// RV32I encoding fields
localparam logic [6:0] OPC_OP     = 7'b0110011;
localparam logic [6:0] OPC_IMM    = 7'b0010011;
localparam logic [6:0] OPC_LUI    = 7'b0110111;
localparam logic [6:0] OPC_LOAD   = 7'b0000011;
localparam logic [6:0] OPC_STORE  = 7'b0100011;
localparam logic [6:0] OPC_BRANCH = 7'b1100011;
localparam logic [2:0] F3_ADD     = 3'b000;
localparam logic [2:0] F3_XOR     = 3'b100;
localparam logic [2:0] F3_OR      = 3'b110;
localparam logic [2:0] F3_AND     = 3'b111;
localparam logic [2:0] F3_WORD    = 3'b010;
localparam logic [2:0] F3_BEQ     = 3'b000;
localparam logic [2:0] F3_BNE     = 3'b001;

typedef struct packed {
    logic [31:0] addr;
    logic [31:0] data;
} store_t;

logic        clk = 1'b0;
logic        rst_n;
logic        mm_data_rdy;
logic [31:0] mm_rd_data;
logic [31:0] mm_wr_data;
logic [31:0] mm_addr;
logic [31:0] mm_wr_addr;
logic        mm_rd;
logic        mm_wr;

logic [31:0] mem [MEM_WORDS];
logic [31:0] prog [$];
store_t      exp_stores [$];
int          run_modes [$];
integer      seed;
int          errors;

segre_core u_segre_core (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .mm_data_rdy_i (mm_data_rdy),
    .mm_rd_data_i  (mm_rd_data),
    .mm_wr_data_o  (mm_wr_data),
    .mm_addr_o     (mm_addr),
    .mm_wr_addr_o  (mm_wr_addr),
    .mm_rd_o       (mm_rd),
    .mm_wr_o       (mm_wr)
);

always #CLK_HALF clk = ~clk;

function automatic logic [31:0] r_format(input logic [6:0] funct7, input logic [2:0] funct3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
    return {funct7, rs2, rs1, funct3, rd, OPC_OP};
endfunction

function automatic logic [31:0] i_format(input logic [6:0] opcode, input logic [2:0] funct3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
    return {imm, rs1, funct3, rd, opcode};
endfunction

function automatic logic [31:0] s_format(input logic [4:0] rs1, input logic [4:0] rs2,
                                         input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, F3_WORD, imm[4:0], OPC_STORE};
endfunction

function automatic logic [31:0] b_format(input logic [2:0] funct3, input logic [4:0] rs1,
                                         input logic [4:0] rs2, input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, funct3, imm[4:1], imm[11], OPC_BRANCH};
endfunction

task automatic abort_run();
    $display("Regression failed");
    $fatal(1, "simulation stopped at the first error");
endtask

task automatic check_value(input string name, input logic [31:0] got,
                           input logic [31:0] expected);
    if (got !== expected) begin
        errors++;
        $display("CHECK FAILED at time %0t: %s got 0x%08h expected 0x%08h",
                 $time, name, got, expected);
        abort_run();
    end
endtask

task automatic build_tables();
    // x1 to x11 exercise every ALU operation with results stored from 0x200 upwards
    prog.push_back({20'h12345, 5'd1, OPC_LUI});
    prog.push_back(i_format(OPC_IMM, F3_ADD, 5'd2, 5'd0, 12'h678));
    prog.push_back(r_format(7'h00, F3_ADD, 5'd3, 5'd1, 5'd2));
    prog.push_back(s_format(5'd0, 5'd3, 12'h200));
    prog.push_back(i_format(OPC_IMM, F3_ADD, 5'd4, 5'd0, 12'hFFF));
    prog.push_back(i_format(OPC_IMM, F3_AND, 5'd5, 5'd3, 12'h0F0));
    prog.push_back(i_format(OPC_IMM, F3_OR, 5'd6, 5'd5, 12'h700));
    prog.push_back(i_format(OPC_IMM, F3_XOR, 5'd7, 5'd6, 12'hFFF));
    prog.push_back(s_format(5'd0, 5'd5, 12'h204));
    prog.push_back(s_format(5'd0, 5'd6, 12'h208));
    prog.push_back(s_format(5'd0, 5'd7, 12'h20C));
    prog.push_back(r_format(7'h20, F3_ADD, 5'd8, 5'd2, 5'd1));
    prog.push_back(r_format(7'h00, F3_AND, 5'd9, 5'd3, 5'd7));
    prog.push_back(r_format(7'h00, F3_OR, 5'd10, 5'd1, 5'd6));
    prog.push_back(r_format(7'h00, F3_XOR, 5'd11, 5'd3, 5'd4));
    prog.push_back(s_format(5'd0, 5'd8, 12'h210));
    prog.push_back(s_format(5'd0, 5'd9, 12'h214));
    prog.push_back(s_format(5'd0, 5'd10, 12'h218));
    prog.push_back(s_format(5'd0, 5'd11, 12'h21C));
    // Write to x0, then store it
    prog.push_back(i_format(OPC_IMM, F3_ADD, 5'd0, 5'd0, 12'h005));
    prog.push_back(s_format(5'd0, 5'd0, 12'h220));
    // Load-use pairs on an ALU source and on a store's data operand
    prog.push_back(i_format(OPC_LOAD, F3_WORD, 5'd12, 5'd0, 12'h100));
    prog.push_back(r_format(7'h00, F3_ADD, 5'd13, 5'd12, 5'd2));
    prog.push_back(s_format(5'd0, 5'd13, 12'h224));
    prog.push_back(i_format(OPC_LOAD, F3_WORD, 5'd14, 5'd0, 12'h104));
    prog.push_back(s_format(5'd0, 5'd14, 12'h228));
    // Two taken branches over stores that must not happen, then two fall-throughs
    prog.push_back(b_format(F3_BEQ, 5'd3, 5'd3, 13'd8));
    prog.push_back(s_format(5'd0, 5'd4, 12'h22C));
    prog.push_back(b_format(F3_BNE, 5'd1, 5'd2, 13'd8));
    prog.push_back(s_format(5'd0, 5'd4, 12'h230));
    prog.push_back(b_format(F3_BEQ, 5'd1, 5'd2, 13'd8));
    prog.push_back(b_format(F3_BNE, 5'd3, 5'd3, 13'd8));
    prog.push_back(i_format(OPC_IMM, F3_ADD, 5'd15, 5'd0, 12'h055));
    prog.push_back(s_format(5'd0, 5'd15, 12'h22C));
    prog.push_back(b_format(F3_BEQ, 5'd0, 5'd0, 13'd0));

    exp_stores.push_back(store_t'{32'h0000_0200, 32'h1234_5678});
    exp_stores.push_back(store_t'{32'h0000_0204, 32'h0000_0070});
    exp_stores.push_back(store_t'{32'h0000_0208, 32'h0000_0770});
    exp_stores.push_back(store_t'{32'h0000_020C, 32'hFFFF_F88F});
    exp_stores.push_back(store_t'{32'h0000_0210, 32'hEDCB_B678});
    exp_stores.push_back(store_t'{32'h0000_0214, 32'h1234_5008});
    exp_stores.push_back(store_t'{32'h0000_0218, 32'h1234_5770});
    exp_stores.push_back(store_t'{32'h0000_021C, 32'hEDCB_A987});
    exp_stores.push_back(store_t'{32'h0000_0220, 32'h0000_0000});
    exp_stores.push_back(store_t'{32'h0000_0224, 32'h0BAD_F685});
    exp_stores.push_back(store_t'{32'h0000_0228, 32'h0000_1111});
    exp_stores.push_back(store_t'{32'h0000_022C, 32'h0000_0055});

    // Mode 0 answers at once and mode 1 draws 0 to 3 wait cycles
    run_modes.push_back(0);
    run_modes.push_back(1);
endtask

task automatic load_memory();
    for (int i = 0; i < MEM_WORDS; i++) begin
        // Unsupported opcode in the low byte with the word index above it
        mem[8'(i)] = {16'hA5C3, 8'(i), 8'h00};
    end
    foreach (prog[i]) begin
        mem[8'(i)] = prog[i];
    end
    // Data words at 0x100 and 0x104
    mem[8'h40] = 32'h0BAD_F00D;
    mem[8'h41] = 32'h0000_1111;
endtask

task automatic run_program(input int run_no, input int mode);
    int          cycles;
    int          limit;
    int          st_idx;
    int          drain;
    int          lat;
    int          waited;
    bit          in_req;
    bit          seen_req;
    logic        req_wr;
    logic [31:0] req_addr;
    logic [31:0] req_data;
    store_t      want;
    cycles   = 0;
    st_idx   = 0;
    drain    = 0;
    lat      = 0;
    waited   = 0;
    in_req   = 1'b0;
    seen_req = 1'b0;
    limit    = prog.size() * (MAX_LATENCY + PIPE_CYCLES) * REFETCH_FACTOR;
    load_memory();
    @(negedge clk);
    rst_n       = 1'b0;
    mm_data_rdy = 1'b0;
    repeat (RESET_CYCLES) begin
        @(negedge clk);
        check_value("mm_rd_o", 32'(mm_rd), 32'h0);
        check_value("mm_wr_o", 32'(mm_wr), 32'h0);
    end
    rst_n = 1'b1;
    while (st_idx < exp_stores.size() || drain < DRAIN_CYCLES) begin
        @(negedge clk);
        cycles++;
        if (cycles > limit) begin
            $display("Timeout in run %0d: %0d of %0d stores seen after %0d cycles",
                     run_no, st_idx, exp_stores.size(), cycles);
            abort_run();
        end
        if (st_idx == exp_stores.size()) begin
            drain++;
        end
        if (mm_rd && mm_wr) begin
            $display("Read and write requested together at time %0t", $time);
            abort_run();
        end
        if (!mm_rd && !mm_wr) begin
            in_req      = 1'b0;
            mm_data_rdy = 1'b0;
        end else begin
            if (!in_req) begin
                in_req   = 1'b1;
                waited   = 0;
                lat      = (mode == 0) ? 0 : int'($unsigned($random(seed)) % 4);
                req_wr   = mm_wr;
                req_addr = mm_wr ? mm_wr_addr : mm_addr;
                req_data = mm_wr_data;
                if (!seen_req) begin
                    // The core starts by fetching the reset PC
                    seen_req = 1'b1;
                    check_value("mm_rd_o", 32'(mm_rd), 32'h1);
                    check_value("mm_addr_o", mm_addr, 32'h0);
                end
                if (req_addr >= 32'(MEM_BYTES)) begin
                    $display("Access to address 0x%08h outside the memory model", req_addr);
                    abort_run();
                end
            end else begin
                check_value("mm_wr_o", 32'(mm_wr), 32'(req_wr));
                if (req_wr) begin
                    check_value("mm_wr_addr_o", mm_wr_addr, req_addr);
                    check_value("mm_wr_data_o", mm_wr_data, req_data);
                end else begin
                    check_value("mm_addr_o", mm_addr, req_addr);
                end
            end
            if (waited == lat) begin
                mm_data_rdy = 1'b1;
                if (req_wr) begin
                    if (st_idx >= exp_stores.size()) begin
                        $display("Unexpected store of 0x%08h to address 0x%08h",
                                 req_data, req_addr);
                        abort_run();
                    end
                    want = exp_stores[st_idx];
                    check_value("mm_wr_addr_o", req_addr, want.addr);
                    check_value("mm_wr_data_o", req_data, want.data);
                    mem[req_addr[9:2]] = req_data;
                    st_idx++;
                end else begin
                    mm_rd_data = mem[req_addr[9:2]];
                end
            end else begin
                mm_data_rdy = 1'b0;
                waited++;
            end
        end
    end
    mm_data_rdy = 1'b0;
endtask

initial begin
    errors      = 0;
    seed        = 32'h36fe;
    rst_n       = 1'b0;
    mm_data_rdy = 1'b0;
    mm_rd_data  = '0;
    build_tables();
    for (int r = 0; r < run_modes.size(); r++) begin
        run_program(r, run_modes[r]);
    end
    if (errors == 0) begin
        $display("Regression passed");
        $finish;
    end else begin
        abort_run();
    end
end

endmodule : tb_segre_core
